// File: include/zkbd_config.svh
/*
 * keyboard/mouse front end configuration
 * matrix geometry, SPI command codes and Z80 port codes
 */
`ifndef ZKBD_CONFIG_SVH
`define ZKBD_CONFIG_SVH

// key matrix geometry, 40 keys
`define ZKBD_ROWS 8
`define ZKBD_COLS 5

// SPI command codes, first byte of a frame
`define ZKBD_CMD_KBD    8'h01
`define ZKBD_CMD_MUSX   8'h02
`define ZKBD_CMD_MUSY   8'h03
`define ZKBD_CMD_MUSBTN 8'h04
`define ZKBD_CMD_JOY    8'h05

`define ZKBD_KBD_BYTES 5 // keyboard payload length

// low address bytes of the Kempston ports
`define ZKBD_PORT_MUS 8'hDF
`define ZKBD_PORT_JOY 8'h1F

`endif

// File: src.f
+incdir+include
src/zkbd_cmd_pkg.sv
src/zkbd_port_pkg.sv
src/spi_byte_rx.sv
src/input_loader.sv
src/input_regs.sv
src/port_read_mux.sv
src/zkbd_top.sv
verif/zkbd_sva.sv
verif/zkbd_tb.sv

// File: src/input_loader.sv
/*
 * SPI command parser
 * decodes the command byte of each frame and issues one load strobe with payload
 */
`timescale 1ns/1ps
`default_nettype none

`include "zkbd_config.svh"

module input_loader (
	input  wire                      fclk,
	input  wire                      arst_n,
	input  wire                      byte_valid,
	input  zkbd_cmd_pkg::spi_word_t  byte_word,
	input  wire                      frame_end,
	output zkbd_cmd_pkg::load_t      load
);
	import zkbd_cmd_pkg::*;

	localparam logic [2:0] KBD_LAST = 3'(`ZKBD_KBD_BYTES - 1);

	loader_state_e state;
	spi_byte_t     cmd;
	logic [2:0]    kbd_cnt;
	key_matrix_t   kbd_acc; // payload gathered low byte first
	logic          cmd_byte;
	logic          pay_valid;

	assign cmd_byte  = byte_valid & byte_word.first & ~frame_end;
	assign pay_valid = byte_valid & ~byte_word.first & ~frame_end;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= IDLE;
			cmd     <= '0;
			kbd_cnt <= '0;
			load    <= '0;
		end
		else
		begin
			// strobes last one cycle
			load.kbd    <= 1'b0;
			load.musx   <= 1'b0;
			load.musy   <= 1'b0;
			load.musbtn <= 1'b0;
			load.joy    <= 1'b0;

			if (frame_end)
				state <= IDLE; // cs_n rose, abort
			else if (cmd_byte)
			begin
				cmd   <= byte_word.data;
				state <= CMD;
			end
			else
			begin
				case (state)
					CMD:
					begin
						kbd_cnt <= '0;
						case (cmd)
							`ZKBD_CMD_KBD:    state <= KBD_PAY;
							`ZKBD_CMD_MUSX,
							`ZKBD_CMD_MUSY,
							`ZKBD_CMD_MUSBTN,
							`ZKBD_CMD_JOY:    state <= ONE_PAY;
							default:          state <= SKIP; // unknown command
						endcase
					end
					KBD_PAY:
						if (pay_valid)
						begin
							kbd_cnt <= kbd_cnt + 3'd1;
							if (kbd_cnt == KBD_LAST)
							begin
								load.kbd      <= 1'b1;
								load.kbd_word <= {byte_word.data, kbd_acc[39:8]};
								state         <= SKIP;
							end
						end
					ONE_PAY:
						if (pay_valid)
						begin
							load.musx     <= (cmd == `ZKBD_CMD_MUSX);
							load.musy     <= (cmd == `ZKBD_CMD_MUSY);
							load.musbtn   <= (cmd == `ZKBD_CMD_MUSBTN);
							load.joy      <= (cmd == `ZKBD_CMD_JOY);
							load.pay_byte <= byte_word.data;
							state         <= SKIP;
						end
					default: ; // IDLE and SKIP wait for the next frame
				endcase
			end
		end
	end

	// shift new bytes in from the top
	always_ff @(posedge fclk)
	begin
		if (state == KBD_PAY && pay_valid)
			kbd_acc <= {byte_word.data, kbd_acc[39:8]};
	end

endmodule

`default_nettype wire

// File: src/input_regs.sv
/*
 * key matrix, Kempston mouse and joystick registers
 * forms the keyboard column word and mouse byte from the high address
 */
`timescale 1ns/1ps
`default_nettype none

`include "zkbd_config.svh"

module input_regs (
	input  wire                       fclk,
	input  wire                       arst_n,
	input  zkbd_cmd_pkg::load_t       load,
	input  zkbd_port_pkg::zdata_t     zah,
	output zkbd_port_pkg::key_row_t   key_cols,
	output zkbd_port_pkg::zdata_t     mus_sel,
	output zkbd_port_pkg::zdata_t     joy
);
	import zkbd_cmd_pkg::*;
	import zkbd_port_pkg::*;

	key_matrix_t key_matrix;
	zdata_t      mus_x;
	zdata_t      mus_y;
	zdata_t      mus_btn;
	logic [4:0]  joy_r; // Kempston uses 5 bits
	key_row_t    cols;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			key_matrix <= '0;   // nothing pressed
			mus_x      <= '0;
			mus_y      <= '0;
			mus_btn    <= 8'hFF; // buttons released
			joy_r      <= '0;
		end
		else
		begin
			if (load.kbd)
				key_matrix <= load.kbd_word;
			if (load.musx)
				mus_x <= load.pay_byte;
			if (load.musy)
				mus_y <= load.pay_byte;
			if (load.musbtn)
				mus_btn <= load.pay_byte;
			if (load.joy)
				joy_r <= load.pay_byte[4:0];
		end
	end

	/*
	 * row r is bits r, r+8, .. r+32, with bit r in the top column position.
	 * every selected row (zah bit low) pulls its pressed keys to 0
	 */
	always_comb
	begin
		cols = '1;
		for (int r = 0; r < `ZKBD_ROWS; r++)
		begin
			if (!zah[r])
			begin
				for (int c = 0; c < `ZKBD_COLS; c++)
					cols[`ZKBD_COLS-1-c] = cols[`ZKBD_COLS-1-c] &
						~key_matrix[r + `ZKBD_ROWS*c];
			end
		end
	end

	assign key_cols = cols;

	// FADF buttons, FBDF x, FFDF y
	assign mus_sel = !zah[0] ? mus_btn : (zah[2] ? mus_y : mus_x);

	assign joy = {3'b000, joy_r};

endmodule

`default_nettype wire

// File: src/port_read_mux.sv
/*
 * Z80 I/O read port decoder
 * picks keyboard, mouse or joystick byte and holds it under valid/ready
 */
`timescale 1ns/1ps
`default_nettype none

`include "zkbd_config.svh"

module port_read_mux (
	input  wire                       fclk,
	input  wire                       arst_n,
	input  wire                       req_valid,
	input  zkbd_port_pkg::io_req_t    req,
	output logic                      req_ready,
	output logic                      resp_valid,
	output zkbd_port_pkg::io_resp_t   resp,
	input  wire                       resp_ready,
	output zkbd_port_pkg::zdata_t     zah,
	input  zkbd_port_pkg::key_row_t   key_cols,
	input  zkbd_port_pkg::zdata_t     mus_sel,
	input  zkbd_port_pkg::zdata_t     joy
);
	import zkbd_port_pkg::*;

	zdata_t zal;
	zdata_t rd_byte;
	logic   req_xfer;

	assign zah = req.addr[15:8];
	assign zal = req.addr[7:0];

	always_comb
	begin
		if (!zal[0])
			rd_byte = {3'b111, key_cols}; // any even port is the keyboard
		else if (zal == `ZKBD_PORT_MUS)
			rd_byte = mus_sel;
		else if (zal == `ZKBD_PORT_JOY)
			rd_byte = joy;
		else
			rd_byte = 8'hFF; // nothing on the bus
	end

	assign req_ready = ~resp_valid; // one read in flight
	assign req_xfer  = req_valid & req_ready;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			resp_valid <= 1'b0;
		else if (req_xfer)
			resp_valid <= 1'b1;
		else if (resp_ready)
			resp_valid <= 1'b0;
	end

	always_ff @(posedge fclk)
	begin
		if (req_xfer)
			resp.data <= rd_byte; // held until the response leaves
	end

endmodule

`default_nettype wire

// File: src/spi_byte_rx.sv
/*
 * SPI slave byte receiver
 * syncs sck/mosi/cs_n to fclk, assembles MSB-first bytes, flags frame start
 */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_rx (
	input  wire                      fclk,
	input  wire                      arst_n,
	input  wire                      sck,
	input  wire                      mosi,
	input  wire                      cs_n,
	output logic                     byte_valid,
	output zkbd_cmd_pkg::spi_word_t  byte_word,
	output logic                     frame_end
);
	import zkbd_cmd_pkg::*;

	logic [2:0] sck_sync;  // two sync stages plus edge history
	logic [1:0] mosi_sync;
	logic [2:0] cs_sync;
	logic       sck_rise;
	logic       cs_hi;
	logic [2:0] bit_cnt;
	logic       first_pend; // next byte opens a frame
	logic [6:0] shift;

	assign sck_rise  = sck_sync[1] & ~sck_sync[2];
	assign cs_hi     = cs_sync[1];
	assign frame_end = cs_sync[1] & ~cs_sync[2];

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sck_sync   <= '0;
			mosi_sync  <= '0;
			cs_sync    <= '1; // deselected
			bit_cnt    <= '0;
			first_pend <= 1'b1;
			byte_valid <= 1'b0;
		end
		else
		begin
			sck_sync   <= {sck_sync[1:0], sck};
			mosi_sync  <= {mosi_sync[0], mosi};
			cs_sync    <= {cs_sync[1:0], cs_n};
			byte_valid <= 1'b0;

			if (cs_hi)
			begin
				// drop any partial byte
				bit_cnt    <= '0;
				first_pend <= 1'b1;
			end
			else if (sck_rise)
			begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7)
				begin
					byte_valid <= 1'b1;
					first_pend <= 1'b0;
				end
			end
		end
	end

	// data path
	always_ff @(posedge fclk)
	begin
		if (!cs_hi && sck_rise)
		begin
			shift <= {shift[5:0], mosi_sync[1]};
			if (bit_cnt == 3'd7)
			begin
				byte_word.data  <= {shift, mosi_sync[1]};
				byte_word.first <= first_pend;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/zkbd_cmd_pkg.sv
/*
 * SPI side types
 * received bytes, key matrix, load strobes and loader states
 */
`default_nettype none

`include "zkbd_config.svh"

package zkbd_cmd_pkg;

	typedef logic [7:0] spi_byte_t;

	// one received byte, first set right after cs_n falls
	typedef struct packed {
		spi_byte_t data;
		logic      first;
	} spi_word_t;

	typedef logic [`ZKBD_ROWS*`ZKBD_COLS-1:0] key_matrix_t; // 1 = pressed

	// at most one strobe high per cycle
	typedef struct packed {
		logic        kbd;
		logic        musx;
		logic        musy;
		logic        musbtn;
		logic        joy;
		key_matrix_t kbd_word;
		spi_byte_t   pay_byte; // payload of the one-byte commands
	} load_t;

	typedef enum logic [2:0] {
		IDLE,
		CMD,
		KBD_PAY,
		ONE_PAY,
		SKIP
	} loader_state_e;

endpackage

`default_nettype wire

// File: src/zkbd_port_pkg.sv
/*
 * Z80 side types
 * I/O address and data, key row, read request and response
 */
`default_nettype none

`include "zkbd_config.svh"

package zkbd_port_pkg;

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	// column bits of the keyboard port, active low
	typedef logic [`ZKBD_COLS-1:0] key_row_t;

	typedef struct packed {
		zaddr_t addr;
	} io_req_t;

	typedef struct packed {
		zdata_t data;
	} io_resp_t;

endpackage

`default_nettype wire

// File: src/zkbd_top.sv
/*
 * keyboard and mouse front end
 * SPI frames from the microcontroller in, Z80 port reads out
 */
`timescale 1ns/1ps
`default_nettype none

module zkbd_top (
	input  wire                       fclk,
	input  wire                       arst_n,
	input  wire                       sck,
	input  wire                       mosi,
	input  wire                       cs_n,
	input  wire                       req_valid,
	input  zkbd_port_pkg::io_req_t    req,
	output logic                      req_ready,
	output logic                      resp_valid,
	output zkbd_port_pkg::io_resp_t   resp,
	input  wire                       resp_ready
);
	import zkbd_cmd_pkg::*;
	import zkbd_port_pkg::*;

	logic      byte_valid;
	spi_word_t byte_word;
	logic      frame_end;
	load_t     load;
	zdata_t    zah;
	key_row_t  key_cols;
	zdata_t    mus_sel;
	zdata_t    joy;

	spi_byte_rx u_rx (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.sck        (sck),
		.mosi       (mosi),
		.cs_n       (cs_n),
		.byte_valid (byte_valid),
		.byte_word  (byte_word),
		.frame_end  (frame_end)
	);

	input_loader u_loader (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.byte_valid (byte_valid),
		.byte_word  (byte_word),
		.frame_end  (frame_end),
		.load       (load)
	);

	input_regs u_regs (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.load     (load),
		.zah      (zah),
		.key_cols (key_cols),
		.mus_sel  (mus_sel),
		.joy      (joy)
	);

	port_read_mux u_mux (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp       (resp),
		.resp_ready (resp_ready),
		.zah        (zah),
		.key_cols   (key_cols),
		.mus_sel    (mus_sel),
		.joy        (joy)
	);

endmodule

`default_nettype wire

// File: verif/zkbd_sva.sv
/*
 * handshake and load strobe assertions for the keyboard front end
 */
`timescale 1ns/1ps
`default_nettype none

module zkbd_sva (
	input wire                      fclk,
	input wire                      arst_n,
	input wire                      req_valid,
	input wire                      req_ready,
	input wire                      resp_valid,
	input wire                      resp_ready,
	input zkbd_port_pkg::io_resp_t  resp,
	input zkbd_cmd_pkg::load_t      load
);

	int fail_cnt = 0; // assertion failures so far

	// stalled response keeps valid and data
	assert property (@(posedge fclk) disable iff (!arst_n)
		(resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
		else
		begin
			$error("response changed or dropped while stalled");
			fail_cnt++;
		end

	assert property (@(posedge fclk) disable iff (!arst_n)
		resp_valid |-> !req_ready)
		else
		begin
			$error("req_ready high with a response pending");
			fail_cnt++;
		end

	assert property (@(posedge fclk) disable iff (!arst_n)
		$onehot0({load.kbd, load.musx, load.musy, load.musbtn, load.joy}))
		else
		begin
			$error("more than one load strobe in a cycle");
			fail_cnt++;
		end

	// one cycle read latency
	assert property (@(posedge fclk) disable iff (!arst_n)
		(req_valid && req_ready) |=> resp_valid)
		else
		begin
			$error("no response one cycle after the request");
			fail_cnt++;
		end

endmodule

bind zkbd_top zkbd_sva u_sva (
	.fclk       (fclk),
	.arst_n     (arst_n),
	.req_valid  (req_valid),
	.req_ready  (req_ready),
	.resp_valid (resp_valid),
	.resp_ready (resp_ready),
	.resp       (resp),
	.load       (load)
);

`default_nettype wire

// File: verif/zkbd_tb.sv
/*
 * testbench for the keyboard and mouse front end
 * loads frames over SPI, checks Z80 port reads against a shadow model
 */
`timescale 1ns/1ps
`default_nettype none

`include "zkbd_config.svh"

module zkbd_tb;
	import zkbd_cmd_pkg::*;
	import zkbd_port_pkg::*;

	localparam int FRAMES    = 7;
	localparam int FRAME_CYC = 6 * 8 * 8 + 20; // longest frame plus select gaps
	localparam int READS     = 37;
	localparam int MAX_STALL = 12;
	localparam int LIMIT     = 2 * (FRAMES * FRAME_CYC + READS * (4 + MAX_STALL)) + 100;

	logic        fclk;
	logic        arst_n;
	logic        sck;
	logic        mosi;
	logic        cs_n;
	logic        req_valid;
	io_req_t     req;
	logic        req_ready;
	logic        resp_valid;
	io_resp_t    resp;
	logic        resp_ready;

	key_matrix_t m_keys; // shadow registers
	zdata_t      m_x;
	zdata_t      m_y;
	zdata_t      m_btn;
	logic [4:0]  m_joy;

	spi_byte_t   frame_q[$];
	logic [31:0] rnd;
	key_matrix_t km;
	int          cycles;
	int          errs;
	int          tests;
	int          failed;
	int          sva_seen;
	int          i;

	zkbd_top dut (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.sck        (sck),
		.mosi       (mosi),
		.cs_n       (cs_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp       (resp),
		.resp_ready (resp_ready)
	);

	always #20 fclk = ~fclk;

	always @(posedge fclk)
	begin
		cycles = cycles + 1;
		if (cycles > LIMIT)
		begin
			$display("timeout: run went past %0d cycles without finishing", LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// pressed keys of every selected row pull their column low
	function automatic key_row_t key_columns(input key_matrix_t keys, input zdata_t hi);
		key_row_t row;
		key_row_t acc;
		int r;
		begin
			acc = '1;
			for (r = 0; r < `ZKBD_ROWS; r++)
			begin
				row = {keys[r], keys[r+8], keys[r+16], keys[r+24], keys[r+32]};
				if (!hi[r])
					acc = acc & ~row;
			end
			return acc;
		end
	endfunction

	function automatic zdata_t expect_read(input zaddr_t addr);
		begin
			if (!addr[0])
				return {3'b111, key_columns(m_keys, addr[15:8])};
			else if (addr[7:0] == `ZKBD_PORT_MUS)
				return !addr[8] ? m_btn : (addr[10] ? m_y : m_x);
			else if (addr[7:0] == `ZKBD_PORT_JOY)
				return {3'b000, m_joy};
			else
				return 8'hFF;
		end
	endfunction

	// mode 0 at fclk/8 with MSB first
	task automatic send_frame();
		spi_byte_t b;
		int k;
		begin
			@(posedge fclk);
			cs_n <= 1'b0;
			sck  <= 1'b0;
			repeat (4) @(posedge fclk);
			while (frame_q.size() > 0)
			begin
				b = frame_q.pop_front();
				for (k = 7; k >= 0; k--)
				begin
					mosi <= b[k];
					sck  <= 1'b0;
					repeat (4) @(posedge fclk);
					sck <= 1'b1;
					repeat (4) @(posedge fclk);
				end
			end
			sck <= 1'b0;
			repeat (4) @(posedge fclk);
			cs_n <= 1'b1;
			repeat (8) @(posedge fclk); // deselect reaches the loader
		end
	endtask

	task automatic load_keys(input key_matrix_t keys);
		int k;
		begin
			frame_q.push_back(`ZKBD_CMD_KBD);
			for (k = 0; k < `ZKBD_KBD_BYTES; k++)
				frame_q.push_back(keys[8*k +: 8]);
			send_frame();
			m_keys = keys;
		end
	endtask

	task automatic load_byte(input spi_byte_t cmd, input spi_byte_t val);
		begin
			frame_q.push_back(cmd);
			frame_q.push_back(val);
			send_frame();
			case (cmd)
				`ZKBD_CMD_MUSX:   m_x = val;
				`ZKBD_CMD_MUSY:   m_y = val;
				`ZKBD_CMD_MUSBTN: m_btn = val;
				`ZKBD_CMD_JOY:    m_joy = val[4:0];
				default: ;
			endcase
		end
	endtask

	// one read with resp_ready withheld for stall cycles
	task automatic check_read(input string name, input zaddr_t addr, input int stall);
		zdata_t exp;
		zdata_t held;
		int s;
		begin
			exp = expect_read(addr);
			@(posedge fclk);
			req_valid  <= 1'b1;
			req.addr   <= addr;
			resp_ready <= 1'b0;
			@(negedge fclk);
			while (!req_ready)
				@(negedge fclk);
			@(posedge fclk); // request transfers here
			req_valid <= 1'b0;
			@(negedge fclk);
			while (!resp_valid)
				@(negedge fclk);
			held = resp.data;
			for (s = 0; s < stall; s++)
			begin
				@(negedge fclk);
				assert (resp.data === held)
				else
				begin
					$display("FAIL %s stall expected %h actual %h", name, held, resp.data);
					errs++;
				end
				assert (resp_valid && !req_ready)
				else
				begin
					$display("%s: handshake moved while the response was stalled", name);
					errs++;
				end
			end
			@(posedge fclk);
			resp_ready <= 1'b1;
			@(posedge fclk); // response transfers here
			resp_ready <= 1'b0;
			assert (held === exp)
			else
			begin
				$display("FAIL %s port %h expected %h actual %h", name, addr, exp, held);
				errs++;
			end
		end
	endtask

	task automatic end_test(input string name);
		begin
			errs     = errs + dut.u_sva.fail_cnt - sva_seen;
			sva_seen = dut.u_sva.fail_cnt;
			tests++;
			if (errs == 0)
				$display("test %s: ok", name);
			else
			begin
				$display("test %s: %0d errors", name, errs);
				failed++;
			end
			errs = 0;
		end
	endtask

	initial
	begin
		rnd        = $urandom(83);
		fclk       = 1'b0;
		arst_n     = 1'b0;
		sck        = 1'b0;
		mosi       = 1'b0;
		cs_n       = 1'b1;
		req_valid  = 1'b0;
		req        = '0;
		resp_ready = 1'b0;
		cycles     = 0;
		errs       = 0;
		tests      = 0;
		failed     = 0;
		sva_seen   = 0;
		m_keys     = '0;
		m_x        = '0;
		m_y        = '0;
		m_btn      = 8'hFF;
		m_joy      = '0;
		repeat (4) @(posedge fclk);
		arst_n <= 1'b1;

		check_read("reset_kbd", 16'h00FE, 0);
		check_read("reset_btn", 16'hFADF, 0);
		check_read("reset_x", 16'hFBDF, 0);
		check_read("reset_y", 16'hFFDF, 0);
		check_read("reset_joy", 16'h001F, 0);
		end_test("reset");

		rnd = $urandom();
		km[31:0] = rnd;
		rnd = $urandom();
		km[39:32] = rnd[7:0];
		load_keys(km);
		for (i = 0; i < 8; i++)
		begin
			rnd = $urandom();
			check_read("keyboard", {rnd[7:0], 8'hFE}, 0);
		end
		end_test("keyboard");

		rnd = $urandom();
		frame_q.push_back(`ZKBD_CMD_MUSX);
		frame_q.push_back(rnd[7:0]);
		frame_q.push_back(8'h55); // trailing byte to be ignored
		send_frame();
		m_x = rnd[7:0];
		load_byte(`ZKBD_CMD_MUSY, rnd[15:8]);
		load_byte(`ZKBD_CMD_MUSBTN, rnd[23:16]);
		load_byte(`ZKBD_CMD_JOY, rnd[31:24]);
		check_read("mouse_btn", 16'hFADF, 0);
		check_read("mouse_x", 16'hFBDF, 0);
		check_read("mouse_y", 16'hFFDF, 0);
		check_read("joystick", 16'h001F, 0);
		check_read("unused", 16'h007D, 0);
		end_test("mouse_joystick");

		rnd = $urandom();
		frame_q.push_back(`ZKBD_CMD_KBD);
		frame_q.push_back(rnd[7:0]);
		frame_q.push_back(rnd[15:8]);
		frame_q.push_back(rnd[23:16]);
		send_frame(); // cut after 3 payload bytes
		frame_q.push_back(8'h09);
		frame_q.push_back(rnd[31:24]);
		frame_q.push_back(rnd[7:0]);
		send_frame();
		for (i = 0; i < `ZKBD_ROWS; i++)
			check_read("framing_kbd", {~(8'h01 << i), 8'hFE}, 0); // one row per read
		check_read("framing_btn", 16'hFADF, 0);
		check_read("framing_x", 16'hFBDF, 0);
		check_read("framing_y", 16'hFFDF, 0);
		check_read("framing_joy", 16'h001F, 0);
		end_test("framing");

		for (i = 0; i < 6; i++)
		begin
			rnd = $urandom();
			case (rnd[2:0] % 6)
				0:       check_read("stall_kbd", {rnd[15:8], 8'hFE}, 1 + rnd[19:16] % MAX_STALL);
				1:       check_read("stall_btn", 16'hFADF, 1 + rnd[19:16] % MAX_STALL);
				2:       check_read("stall_x", 16'hFBDF, 1 + rnd[19:16] % MAX_STALL);
				3:       check_read("stall_y", 16'hFFDF, 1 + rnd[19:16] % MAX_STALL);
				4:       check_read("stall_joy", 16'h001F, 1 + rnd[19:16] % MAX_STALL);
				default: check_read("stall_none", 16'h007D, 1 + rnd[19:16] % MAX_STALL);
			endcase
		end
		end_test("backpressure");

		$display("tests %0d, passed %0d, failed %0d", tests, tests - failed, failed);
		if (failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
